// ==== design/scurve_types_pkg.sv ====
package scurve_types_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Injection and trigger counters
  localparam int COUNT_W = 16;
  // Trigger delay select, 0 to 15 clocks
  localparam int DELAY_W = 4;

  // Count of injections or triggers
  typedef logic [COUNT_W-1:0] count_t;
  // Trigger delay in clocks
  typedef logic [DELAY_W-1:0] delay_t;

  //////////////////////////////////////////////////
  // Per-channel outputs
  //////////////////////////////////////////////////
  typedef struct packed {
    count_t pulse;
    count_t trigger;
    logic   done;
  } chan_result_t;

endpackage

// ==== design/scurve_cfg_pkg.sv ====
package scurve_cfg_pkg;

  import scurve_types_pkg::*;

  // Host bus widths
  typedef logic [7:0]  addr_t;
  typedef logic [15:0] data_t;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////
  localparam addr_t ADDR_CTRL       = 8'd0;
  localparam addr_t ADDR_CPT_MAX    = 8'd1;
  localparam addr_t ADDR_TRIG_DELAY = 8'd2;
  localparam addr_t ADDR_STATUS     = 8'd3;
  // Per-channel readback windows, base + channel
  localparam addr_t ADDR_PULSE_BASE = 8'd16;
  localparam addr_t ADDR_TRIG_BASE  = 8'd32;

  // CTRL and STATUS bit positions
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_MODE_BIT   = 1;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  typedef enum logic {COUNT_EFFI = 1'b0, TRIG_EFFI = 1'b1} scan_mode_e;

  typedef struct packed {
    scan_mode_e mode;
    count_t     cpt_max;
    delay_t     trig_delay;
  } scan_cfg_t;

  // Four-phase host bus
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } host_req_t;

  typedef struct packed {
    logic  ack;
    data_t rdata;
  } host_rsp_t;

endpackage

// ==== design/scurve_cfg_regs.sv ====
`timescale 1ns/1ps

module scurve_cfg_regs
  import scurve_types_pkg::*;
  import scurve_cfg_pkg::*;
#(
  parameter int NUM_CH = 4
) (
  input  logic                      Clk,
  input  logic                      reset_n,
  input  host_req_t                 host_req,
  output host_rsp_t                 host_rsp,
  input  chan_result_t [NUM_CH-1:0] results,
  input  logic                      busy,
  input  logic                      done,
  output scan_cfg_t                 cfg,
  output logic                      start_pulse
);

  typedef enum logic {IDLE, ACK} hs_state_e;

  hs_state_e state;
  // One access per handshake, on the IDLE to ACK step
  logic      access;
  data_t     rd_data;
  data_t     rdata;

  assign access = (state == IDLE) && host_req.req;

  //////////////////////////////////////////////////
  // Handshake FSM and register writes
  //////////////////////////////////////////////////
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= IDLE;
      start_pulse <= 1'b0;
      cfg         <= '{mode: COUNT_EFFI, cpt_max: '0, trig_delay: '0};
    end else begin
      // Start bit clears itself
      start_pulse <= 1'b0;
      case (state)
        // Ack goes up the cycle after req is seen
        IDLE: if (host_req.req) state <= ACK;
        // And down the cycle after req is gone
        ACK: if (!host_req.req) state <= IDLE;
        default: state <= IDLE;
      endcase
      if (access && host_req.we) begin
        case (host_req.addr)
          ADDR_CTRL: begin
            cfg.mode    <= scan_mode_e'(host_req.wdata[CTRL_MODE_BIT]);
            start_pulse <= host_req.wdata[CTRL_START_BIT];
          end
          ADDR_CPT_MAX:    cfg.cpt_max    <= host_req.wdata;
          ADDR_TRIG_DELAY: cfg.trig_delay <= host_req.wdata[DELAY_W-1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Readback mux
  //////////////////////////////////////////////////
  always_comb begin
    // Unmapped addresses read as zero
    rd_data = '0;
    case (host_req.addr)
      ADDR_CTRL:       rd_data[CTRL_MODE_BIT] = cfg.mode;
      ADDR_CPT_MAX:    rd_data = cfg.cpt_max;
      ADDR_TRIG_DELAY: rd_data[DELAY_W-1:0] = cfg.trig_delay;
      ADDR_STATUS: begin
        rd_data[STATUS_BUSY_BIT] = busy;
        rd_data[STATUS_DONE_BIT] = done;
      end
      default: begin
        // Channel windows
        for (int ch = 0; ch < NUM_CH; ch++) begin
          if (host_req.addr == addr_t'(ADDR_PULSE_BASE + ch)) rd_data = results[ch].pulse;
          if (host_req.addr == addr_t'(ADDR_TRIG_BASE + ch)) rd_data = results[ch].trigger;
        end
      end
    endcase
  end

  // Read data held for the whole ack phase
  always_ff @(posedge Clk) begin
    if (access) rdata <= rd_data;
  end

  assign host_rsp = '{ack: (state == ACK), rdata: rdata};

endmodule

// ==== design/scurve_scan_ctrl.sv ====
`timescale 1ns/1ps

module scurve_scan_ctrl
  import scurve_types_pkg::*;
#(
  parameter int NUM_CH = 4
) (
  input  logic                      Clk,
  input  logic                      reset_n,
  input  logic                      start_pulse,
  input  chan_result_t [NUM_CH-1:0] results,
  output logic                      clear,
  output logic                      run,
  output logic                      busy,
  output logic                      done
);

  typedef enum logic [1:0] {IDLE, CLEAR, RUN, FINISHED} scan_state_e;

  scan_state_e       state;
  scan_state_e       state_next;
  logic [NUM_CH-1:0] chan_done;
  // Every channel reached its limit
  logic              all_done;

  // Gather the done flags
  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      chan_done[ch] = results[ch].done;
    end
  end

  assign all_done = &chan_done;

  //////////////////////////////////////////////////
  // Scan sequencing
  //////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      IDLE:     if (start_pulse) state_next = CLEAR;
      // Single clear cycle, then run
      CLEAR:    state_next = RUN;
      // Stale done bits are gone by the first RUN cycle
      // Start is ignored here
      RUN:      if (all_done) state_next = FINISHED;
      // Rescan without reset
      FINISHED: if (start_pulse) state_next = CLEAR;
      default:  state_next = IDLE;
    endcase
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Outputs decoded from the state register
  assign clear = (state == CLEAR);
  assign run   = (state == RUN);
  assign busy  = (state == CLEAR) || (state == RUN);
  // Held until the next start
  assign done  = (state == FINISHED);

endmodule

// ==== design/scurve_channel_counter.sv ====
`timescale 1ns/1ps

module scurve_channel_counter
  import scurve_types_pkg::*;
  import scurve_cfg_pkg::*;
(
  input  logic         Clk,
  input  logic         reset_n,
  input  scan_cfg_t    cfg,
  input  logic         clear,
  input  logic         run,
  input  logic         clk_ext,
  input  logic         trigger,
  output chan_result_t result
);

  // Injection strobe path
  logic        ext_meta;
  logic        ext_sync;
  logic        ext_prev;
  logic        ext_rise;
  logic        ext_fall;
  // Trigger path
  logic        trig_meta;
  logic [15:0] trig_shift;
  logic        trig_delayed;
  logic        trig_level;
  logic        trig_level_next;
  logic        trig_fall;
  // Enables
  logic        count_en;
  logic        window_en;
  // Counters and done
  count_t      pulse_cnt;
  count_t      trig_cnt;
  logic        pulse_full;
  logic        done_q;

  //////////////////////////////////////////////////
  // Synchronizers
  //////////////////////////////////////////////////

  // clk_ext, two flops plus the edge register
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      ext_meta <= 1'b0;
      ext_sync <= 1'b0;
      ext_prev <= 1'b0;
    end else begin
      ext_meta <= clk_ext;
      ext_sync <= ext_meta;
      ext_prev <= ext_sync;
    end
  end

  assign ext_rise = ext_sync & ~ext_prev;
  assign ext_fall = ~ext_sync & ext_prev;

  // Trigger idles high
  // Shift bit 0 is the second sync stage, the rest is the delay line
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trig_meta  <= 1'b1;
      trig_shift <= '1;
    end else begin
      trig_meta  <= trigger;
      trig_shift <= {trig_shift[14:0], trig_meta};
    end
  end

  // Tap 0 means no extra delay
  assign trig_delayed = trig_shift[cfg.trig_delay];

  //////////////////////////////////////////////////
  // Mode gating
  //////////////////////////////////////////////////
  assign count_en  = run & ~done_q;
  // Trigger efficiency only looks inside the injection window
  assign window_en = (cfg.mode == TRIG_EFFI) ? (count_en & ext_sync) : count_en;

  always_comb begin
    if (cfg.mode == TRIG_EFFI) begin
      // Low sticks until the window closes
      trig_level_next = (trig_delayed & trig_level) | ~window_en;
    end else begin
      trig_level_next = trig_delayed;
    end
  end

  // One register doubles as hold state and edge detector
  assign trig_fall = trig_level & ~trig_level_next;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trig_level <= 1'b1;
    end else if (clear) begin
      trig_level <= 1'b1;
    end else begin
      trig_level <= trig_level_next;
    end
  end

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////
  assign pulse_full = (pulse_cnt == cfg.cpt_max);

  // Injections, stops at the limit
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      pulse_cnt <= '0;
    end else if (clear) begin
      pulse_cnt <= '0;
    end else if (count_en && ext_rise && (pulse_cnt < cfg.cpt_max)) begin
      pulse_cnt <= pulse_cnt + 1'b1;
    end
  end

  // Trigger falls, until done
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      trig_cnt <= '0;
    end else if (clear) begin
      trig_cnt <= '0;
    end else if (window_en && trig_fall) begin
      trig_cnt <= trig_cnt + 1'b1;
    end
  end

  // Sticky done at the window close after the last injection
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      done_q <= 1'b0;
    end else if (clear) begin
      done_q <= 1'b0;
    end else if (run && ext_fall && pulse_full) begin
      done_q <= 1'b1;
    end
  end

  assign result = '{pulse: pulse_cnt, trigger: trig_cnt, done: done_q};

endmodule

// ==== design/scurve_scan_top.sv ====
`timescale 1ns/1ps

module scurve_scan_top
  import scurve_types_pkg::*;
  import scurve_cfg_pkg::*;
#(
  parameter int NUM_CH = 4
) (
  input  logic              Clk,
  input  logic              reset_n,
  input  host_req_t         host_req,
  output host_rsp_t         host_rsp,
  input  logic              clk_ext,
  input  logic [NUM_CH-1:0] trigger,
  output logic              scan_done
);

  scan_cfg_t                 cfg;
  logic                      start_pulse;
  logic                      clear;
  logic                      run;
  logic                      busy;
  logic                      done;
  // All channel outputs, to the controller and the readback
  chan_result_t [NUM_CH-1:0] results;

  scurve_cfg_regs #(.NUM_CH(NUM_CH)) cfg_regs_i (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .results     (results),
    .busy        (busy),
    .done        (done),
    .cfg         (cfg),
    .start_pulse (start_pulse)
  );

  scurve_scan_ctrl #(.NUM_CH(NUM_CH)) scan_ctrl_i (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .start_pulse (start_pulse),
    .results     (results),
    .clear       (clear),
    .run         (run),
    .busy        (busy),
    .done        (done)
  );

  // One counter per discriminator, shared strobe
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_chan
    scurve_channel_counter chan_i (
      .Clk     (Clk),
      .reset_n (reset_n),
      .cfg     (cfg),
      .clear   (clear),
      .run     (run),
      .clk_ext (clk_ext),
      .trigger (trigger[ch]),
      .result  (results[ch])
    );
  end

  assign scan_done = done;

endmodule

// ==== test/scurve_scan_chk.sv ====
`timescale 1ns/1ps

module scurve_scan_chk
  import scurve_cfg_pkg::*;
(
  input logic      Clk,
  input logic      reset_n,
  input host_req_t host_req,
  input host_rsp_t host_rsp,
  input logic      clk_ext,
  input logic      scan_done
);

  // Failed properties so far
  int unsigned fail_count = 0;

  //////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////

  // Ack only answers a request that was seen the cycle before
  ack_rise_a: assert property (@(posedge Clk) disable iff (!reset_n)
    $rose(host_rsp.ack) |-> $past(host_req.req)) else begin
    fail_count++;
    $error("ack rose without a pending request");
  end

  // Ack drops only once req is gone
  ack_fall_a: assert property (@(posedge Clk) disable iff (!reset_n)
    $fell(host_rsp.ack) |-> !$past(host_req.req)) else begin
    fail_count++;
    $error("ack fell while req was still high");
  end

  // Request fields held until ack
  req_stable_a: assert property (@(posedge Clk) disable iff (!reset_n)
    host_req.req && !host_rsp.ack |=> host_rsp.ack || $stable(host_req)) else begin
    fail_count++;
    $error("host request changed before ack");
  end

  // Scan ends in the gap between injections
  done_rise_a: assert property (@(posedge Clk) disable iff (!reset_n)
    $rose(scan_done) |-> !clk_ext) else begin
    fail_count++;
    $error("scan_done rose while clk_ext was high");
  end

endmodule

bind scurve_scan_top scurve_scan_chk chk_i (
  .Clk       (Clk),
  .reset_n   (reset_n),
  .host_req  (host_req),
  .host_rsp  (host_rsp),
  .clk_ext   (clk_ext),
  .scan_done (scan_done)
);

// ==== test/scurve_scan_tb.sv ====
`timescale 1ns/1ps

module scurve_scan_tb
  import scurve_types_pkg::*;
  import scurve_cfg_pkg::*;
();

  localparam int    NUM_CH     = 4;
  localparam int    CLK_PERIOD = 20;
  // Injection period in clocks, window high at the start
  localparam int    INJ_LEN    = 40;
  localparam int    INJ_HIGH   = 24;
  localparam data_t CPT_MAX    = 16'd20;
  localparam int    ACK_LIMIT  = 20;
  // Five scans plus slack
  localparam int    WATCHDOG_CYCLES = 5 * (int'(CPT_MAX) + 2) * INJ_LEN + 2000;

  logic              Clk;
  logic              reset_n;
  host_req_t         host_req;
  host_rsp_t         host_rsp;
  logic              clk_ext;
  logic [NUM_CH-1:0] trigger;
  logic              scan_done;

  int                 errors;
  scan_mode_e         cur_mode;
  int                 cur_delay;
  // Trigger level per channel over one injection period
  logic [INJ_LEN-1:0] pattern [NUM_CH];
  logic [NUM_CH-1:0]  window_hit;
  // Model of the trigger counters
  data_t              exp_trig [NUM_CH];

  scurve_scan_top #(.NUM_CH(NUM_CH)) dut_i (
    .Clk       (Clk),
    .reset_n   (reset_n),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .clk_ext   (clk_ext),
    .trigger   (trigger),
    .scan_done (scan_done)
  );

  always #(CLK_PERIOD / 2) Clk = ~Clk;

  //////////////////////////////////////////////////
  // Host bus
  //////////////////////////////////////////////////
  task automatic host_access(input logic we, input addr_t addr, input data_t wdata,
                             output data_t data);
    int cycles;
    @(negedge Clk);
    host_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    cycles = 0;
    while (!host_rsp.ack && cycles < ACK_LIMIT) begin
      @(negedge Clk);
      cycles++;
    end
    if (!host_rsp.ack) begin
      errors++;
      $display("no ack for the access to address %0d", addr);
    end
    data = host_rsp.rdata;
    host_req.req = 1'b0;
    cycles = 0;
    while (host_rsp.ack && cycles < ACK_LIMIT) begin
      @(negedge Clk);
      cycles++;
    end
    if (host_rsp.ack) begin
      errors++;
      $display("ack stayed high after req dropped, address %0d", addr);
    end
  endtask

  task automatic host_write(input addr_t addr, input data_t wdata);
    data_t ignored;
    host_access(1'b1, addr, wdata, ignored);
  endtask

  task automatic host_read(input addr_t addr, output data_t data);
    host_access(1'b0, addr, '0, data);
  endtask

  task automatic expect_reg(input addr_t addr, input string name, input data_t exp);
    data_t got;
    host_read(addr, got);
    assert (got == exp) else begin
      errors++;
      $display("mismatch at %0d ns: %s read 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Injections and expected counts
  //////////////////////////////////////////////////

  // Two low clocks at off, model follows the mode rules
  task automatic add_fall(input int ch, input int off, input bit last);
    int eff;
    eff = off + cur_delay;
    pattern[ch][off]     = 1'b0;
    pattern[ch][off + 1] = 1'b0;
    if (cur_mode == TRIG_EFFI) begin
      if (eff < INJ_HIGH) window_hit[ch] = 1'b1;
    end else if (!(last && eff >= INJ_HIGH)) begin
      exp_trig[ch] = exp_trig[ch] + 16'd1;
    end
  endtask

  task automatic inject(input bit last, input bit fixed_fall);
    int n_in;
    window_hit = '0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      pattern[ch] = '1;
      if (fixed_fall) begin
        // Eight clocks before the window closes
        add_fall(ch, INJ_HIGH - 8, last);
      end else begin
        n_in = $urandom_range(3, 0);
        for (int k = 0; k < n_in; k++)
          add_fall(ch, 4 + 5 * k + $urandom_range(1, 0), last);
        // Sometimes one more in the gap
        if (!last && $urandom_range(1, 0) == 1)
          add_fall(ch, INJ_HIGH + 4 + $urandom_range(4, 0), last);
      end
    end
    for (int c = 0; c < INJ_LEN; c++) begin
      @(negedge Clk);
      clk_ext = (c < INJ_HIGH);
      for (int ch = 0; ch < NUM_CH; ch++)
        trigger[ch] = pattern[ch][c];
    end
    // One count per window that saw a fall
    if (cur_mode == TRIG_EFFI) begin
      for (int ch = 0; ch < NUM_CH; ch++)
        exp_trig[ch] = exp_trig[ch] + data_t'(window_hit[ch]);
    end
  endtask

  task automatic run_scan(input scan_mode_e mode, input int delay, input bit fixed_fall);
    data_t ctrl;
    int    cycles;
    cur_mode  = mode;
    cur_delay = delay;
    for (int ch = 0; ch < NUM_CH; ch++)
      exp_trig[ch] = '0;
    host_write(ADDR_CPT_MAX, CPT_MAX);
    host_write(ADDR_TRIG_DELAY, data_t'(delay));
    ctrl = '0;
    ctrl[CTRL_START_BIT] = 1'b1;
    ctrl[CTRL_MODE_BIT]  = mode;
    host_write(ADDR_CTRL, ctrl);
    // Busy, and the last scan's counts are gone
    expect_reg(ADDR_STATUS, "STATUS", 16'h0001);
    assert (scan_done == 1'b0) else begin
      errors++;
      $display("mismatch at %0d ns: scan_done is %0b, expected 0", $time, scan_done);
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      expect_reg(addr_t'(ADDR_PULSE_BASE + ch), $sformatf("PULSE%0d", ch), '0);
      expect_reg(addr_t'(ADDR_TRIG_BASE + ch), $sformatf("TRIG%0d", ch), '0);
    end
    for (int i = 0; i < int'(CPT_MAX); i++)
      inject(i == int'(CPT_MAX) - 1, fixed_fall);
    cycles = 0;
    while (!scan_done && cycles < INJ_LEN) begin
      @(negedge Clk);
      cycles++;
    end
    if (!scan_done) begin
      errors++;
      $display("scan_done did not rise after the last injection");
    end
    expect_reg(ADDR_STATUS, "STATUS", 16'h0002);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      expect_reg(addr_t'(ADDR_PULSE_BASE + ch), $sformatf("PULSE%0d", ch), CPT_MAX);
      expect_reg(addr_t'(ADDR_TRIG_BASE + ch), $sformatf("TRIG%0d", ch), exp_trig[ch]);
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h91ff44fb));
    Clk      = 1'b0;
    reset_n  = 1'b0;
    host_req = '0;
    clk_ext  = 1'b0;
    trigger  = '1;
    errors   = 0;
    repeat (3) @(negedge Clk);
    reset_n = 1'b1;
    expect_reg(ADDR_STATUS, "STATUS", 16'h0000);
    host_write(ADDR_CPT_MAX, 16'hA5C3);
    host_write(ADDR_TRIG_DELAY, 16'h000B);
    expect_reg(ADDR_CPT_MAX, "CPT_MAX", 16'hA5C3);
    expect_reg(ADDR_TRIG_DELAY, "TRIG_DELAY", 16'h000B);
    expect_reg(8'd100, "unmapped", 16'h0000);
    run_scan(COUNT_EFFI, 0, 1'b0);
    run_scan(TRIG_EFFI, 0, 1'b0);
    // Delay pushes the fall past the window
    run_scan(TRIG_EFFI, 0, 1'b1);
    run_scan(TRIG_EFFI, 12, 1'b1);
    run_scan(COUNT_EFFI, 0, 1'b0);
    $display("errors: %0d checks, %0d assertions", errors, dut_i.chk_i.fail_count);
    if (errors == 0 && dut_i.chk_i.fail_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== scurve_scan.f ====
design/scurve_types_pkg.sv
design/scurve_cfg_pkg.sv
design/scurve_cfg_regs.sv
design/scurve_scan_ctrl.sv
design/scurve_channel_counter.sv
design/scurve_scan_top.sv
test/scurve_scan_chk.sv
test/scurve_scan_tb.sv

// ==== Makefile ====
BIN  := obj_dir/Vscurve_scan_tb
SRCS := $(shell cat scurve_scan.f)

.PHONY: all run check clean

all: check

$(BIN): scurve_scan.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module scurve_scan_tb -f scurve_scan.f

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 > sim.log 2>&1; status=$$?; cat sim.log; exit $$status

check: run
	@if grep -q "Testbench failed" sim.log; then \
	  echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
